//--- logic/dcache_pkg.sv
// data cache shared definitions
package dcache_pkg;

    // geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int LINE_WIDTH     = 256;
    localparam int WORDS_PER_LINE = LINE_WIDTH / DATA_WIDTH;
    localparam int SET_ASSOC      = 4;
    localparam int SET_NUM        = 16;

    // address fields
    localparam int OFFSET_WIDTH   = $clog2(LINE_WIDTH / 8);
    localparam int INDEX_WIDTH    = $clog2(SET_NUM);
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef logic [DATA_WIDTH-1:0]                 word_t;
    typedef logic [DATA_WIDTH/8-1:0]               be_t;
    typedef logic [ADDR_WIDTH-1:0]                 addr_t;
    typedef logic [INDEX_WIDTH-1:0]                index_t;
    typedef logic [TAG_WIDTH-1:0]                  tag_t;
    // line address, tag above index
    typedef logic [TAG_WIDTH+INDEX_WIDTH-1:0]      label_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]     word_sel_t;
    typedef logic [$clog2(SET_ASSOC)-1:0]          way_t;
    typedef logic [SET_ASSOC-1:0]                  way_mask_t;
    typedef word_t [WORDS_PER_LINE-1:0]            line_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // miss handling walks writeback, fetch, wait fill
    typedef enum logic [2:0] {
        RESET,
        IDLE,
        WRITEBACK,
        FETCH,
        WAIT_FILL
    } dcache_state_e;

endpackage

//--- logic/dcache_tag_ram.sv
`timescale 1ns/1ps
// data cache tag store
module dcache_tag_ram (
    input  logic                                             clk,
    input  logic                                             rst,
    input  dcache_pkg::index_t                               rd_index_i,
    input  dcache_pkg::tag_t                                 rd_tag_i,
    input  dcache_pkg::way_mask_t                            wr_en_i,
    input  dcache_pkg::index_t                               wr_index_i,
    input  dcache_pkg::tag_entry_t                           wr_entry_i,
    output dcache_pkg::tag_entry_t [dcache_pkg::SET_ASSOC-1:0] entries_o,
    output dcache_pkg::way_mask_t                            hit_o
);

    dcache_pkg::tag_entry_t mem [dcache_pkg::SET_ASSOC][dcache_pkg::SET_NUM];
    dcache_pkg::tag_t       tag_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::SET_ASSOC; w++) begin
            if (wr_en_i[w]) begin
                mem[w][wr_index_i] <= wr_entry_i;
            end
        end
    end

    // synchronous read with write-first bypass
    always_ff @(posedge clk) begin
        if (rst) begin
            entries_o <= '0;
            tag_q     <= '0;
        end else begin
            tag_q <= rd_tag_i;
            for (int w = 0; w < dcache_pkg::SET_ASSOC; w++) begin
                if (wr_en_i[w] && wr_index_i == rd_index_i) begin
                    entries_o[w] <= wr_entry_i;
                end else begin
                    entries_o[w] <= mem[w][rd_index_i];
                end
            end
        end
    end

    // per-way compare against the registered tag
    for (genvar w = 0; w < dcache_pkg::SET_ASSOC; w++) begin : gen_hit
        assign hit_o[w] = entries_o[w].valid && entries_o[w].tag == tag_q;
    end

endmodule

//--- logic/dcache_data_ram.sv
`timescale 1ns/1ps
// data cache line store
module dcache_data_ram (
    input  logic                                        clk,
    input  dcache_pkg::index_t                          rd_index_i,
    input  dcache_pkg::way_t                            wr_way_i,
    input  dcache_pkg::index_t                          wr_index_i,
    input  logic                                        wr_line_en_i,
    input  dcache_pkg::line_t                           wr_line_i,
    input  logic                                        wr_word_en_i,
    input  dcache_pkg::word_sel_t                       wr_word_sel_i,
    input  dcache_pkg::be_t                             wr_be_i,
    input  dcache_pkg::word_t                           wr_word_i,
    output dcache_pkg::line_t [dcache_pkg::SET_ASSOC-1:0] lines_o
);

    dcache_pkg::line_t mem [dcache_pkg::SET_ASSOC][dcache_pkg::SET_NUM];
    dcache_pkg::line_t new_line;
    logic              wr_en;

    assign wr_en = wr_line_en_i || wr_word_en_i;

    // store hits merge their bytes into the line already held
    always_comb begin
        new_line = wr_line_en_i ? wr_line_i : mem[wr_way_i][wr_index_i];
        if (wr_word_en_i) begin
            for (int b = 0; b < dcache_pkg::DATA_WIDTH / 8; b++) begin
                if (wr_be_i[b]) begin
                    new_line[wr_word_sel_i][8*b +: 8] = wr_word_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::SET_ASSOC; w++) begin
            if (wr_en && wr_way_i == dcache_pkg::way_t'(w)) begin
                mem[w][wr_index_i] <= new_line;
            end
            // write-first bypass
            if (wr_en && wr_way_i == dcache_pkg::way_t'(w) && wr_index_i == rd_index_i) begin
                lines_o[w] <= new_line;
            end else begin
                lines_o[w] <= mem[w][rd_index_i];
            end
        end
    end

endmodule

//--- logic/dcache_plru.sv
`timescale 1ns/1ps
// tree pseudo-LRU replacement
module dcache_plru (
    input  logic               clk,
    input  logic               rst,
    input  logic               access_i,
    input  dcache_pkg::index_t access_index_i,
    input  dcache_pkg::way_t   access_way_i,
    input  dcache_pkg::index_t query_index_i,
    output dcache_pkg::way_t   victim_o
);

    // bit 0 picks the pair, bit 1 the way in the low pair, bit 2 in the high pair
    logic [dcache_pkg::SET_NUM-1:0][dcache_pkg::SET_ASSOC-2:0] tree_q;
    logic [dcache_pkg::SET_ASSOC-2:0]                          query_bits;

    // point every bit on the path away from the accessed way
    always_ff @(posedge clk) begin
        if (rst) begin
            tree_q <= '0;
        end else if (access_i) begin
            tree_q[access_index_i][0] <= ~access_way_i[1];
            if (access_way_i[1]) begin
                tree_q[access_index_i][2] <= ~access_way_i[0];
            end else begin
                tree_q[access_index_i][1] <= ~access_way_i[0];
            end
        end
    end

    assign query_bits = tree_q[query_index_i];

    // follow the bits down to the victim
    assign victim_o = {query_bits[0], query_bits[0] ? query_bits[2] : query_bits[1]};

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps
// data cache controller
module dcache_ctrl (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               req_valid_i,
    input  logic                                               req_write_i,
    input  dcache_pkg::addr_t                                  req_addr_i,
    input  dcache_pkg::be_t                                    req_be_i,
    input  dcache_pkg::word_t                                  req_wdata_i,
    output logic                                               ready_o,
    output logic                                               rd_valid_o,
    output dcache_pkg::word_t                                  rd_data_o,
    input  dcache_pkg::tag_entry_t [dcache_pkg::SET_ASSOC-1:0] tag_entries_i,
    input  dcache_pkg::way_mask_t                              tag_hit_i,
    output dcache_pkg::index_t                                 tag_rd_index_o,
    output dcache_pkg::tag_t                                   tag_rd_tag_o,
    output dcache_pkg::way_mask_t                              tag_wr_en_o,
    output dcache_pkg::index_t                                 tag_wr_index_o,
    output dcache_pkg::tag_entry_t                             tag_wr_entry_o,
    input  dcache_pkg::line_t [dcache_pkg::SET_ASSOC-1:0]      data_lines_i,
    output dcache_pkg::index_t                                 data_rd_index_o,
    output dcache_pkg::way_t                                   data_wr_way_o,
    output dcache_pkg::index_t                                 data_wr_index_o,
    output logic                                               data_wr_line_en_o,
    output dcache_pkg::line_t                                  data_wr_line_o,
    output logic                                               data_wr_word_en_o,
    output dcache_pkg::word_sel_t                              data_wr_word_sel_o,
    output dcache_pkg::be_t                                    data_wr_be_o,
    output dcache_pkg::word_t                                  data_wr_word_o,
    input  dcache_pkg::way_t                                   victim_i,
    output logic                                               plru_access_o,
    output dcache_pkg::index_t                                 plru_index_o,
    output dcache_pkg::way_t                                   plru_way_o,
    output dcache_pkg::index_t                                 plru_query_index_o,
    output logic                                               fill_req_o,
    output dcache_pkg::label_t                                 fill_label_o,
    input  logic                                               fill_valid_i,
    input  dcache_pkg::line_t                                  fill_line_i,
    input  logic                                               wb_full_i,
    output logic                                               wb_valid_o,
    output dcache_pkg::label_t                                 wb_label_o,
    output dcache_pkg::line_t                                  wb_line_o
);

    localparam int SEL_WIDTH = $bits(dcache_pkg::word_sel_t);

    dcache_pkg::dcache_state_e state_q, state_d;
    dcache_pkg::index_t        rst_cnt_q;

    // lookup stage
    logic                      lk_valid_q;
    logic                      lk_write_q;
    dcache_pkg::addr_t         lk_addr_q;
    dcache_pkg::be_t           lk_be_q;
    dcache_pkg::word_t         lk_wdata_q;
    dcache_pkg::index_t        lk_index;
    dcache_pkg::tag_t          lk_tag;
    dcache_pkg::word_sel_t     lk_sel;
    logic                      lk_hit;
    logic                      lk_miss;
    logic                      fill_done;

    dcache_pkg::way_t          hit_way;
    dcache_pkg::way_t          victim_sel;
    dcache_pkg::way_t          victim_q;
    dcache_pkg::line_t         fill_merged;

    assign lk_index = lk_addr_q[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
    assign lk_tag   = lk_addr_q[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
    assign lk_sel   = lk_addr_q[dcache_pkg::OFFSET_WIDTH-1 -: SEL_WIDTH];

    assign lk_hit    = state_q == dcache_pkg::IDLE && lk_valid_q && (|tag_hit_i);
    assign lk_miss   = state_q == dcache_pkg::IDLE && lk_valid_q && !(|tag_hit_i);
    assign fill_done = state_q == dcache_pkg::WAIT_FILL && fill_valid_i;
    assign ready_o   = state_q == dcache_pkg::IDLE && !lk_miss;

    // stores keep the set of a frozen miss on the read port
    assign tag_rd_index_o  = ready_o ?
        req_addr_i[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH] : lk_index;
    assign tag_rd_tag_o    = ready_o ?
        req_addr_i[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH] : lk_tag;
    assign data_rd_index_o = tag_rd_index_o;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::SET_ASSOC; w++) begin
            if (tag_hit_i[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    // lowest invalid way first, then the tree choice
    always_comb begin
        victim_sel = victim_i;
        for (int w = dcache_pkg::SET_ASSOC - 1; w >= 0; w--) begin
            if (!tag_entries_i[w].valid) begin
                victim_sel = dcache_pkg::way_t'(w);
            end
        end
    end

    // write miss lands in the refilled line
    always_comb begin
        fill_merged = fill_line_i;
        for (int b = 0; b < dcache_pkg::DATA_WIDTH / 8; b++) begin
            if (lk_write_q && lk_be_q[b]) begin
                fill_merged[lk_sel][8*b +: 8] = lk_wdata_q[8*b +: 8];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::RESET: begin
                if (rst_cnt_q == dcache_pkg::index_t'(dcache_pkg::SET_NUM - 1)) begin
                    state_d = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::IDLE: begin
                if (lk_miss) begin
                    if (tag_entries_i[victim_sel].valid && tag_entries_i[victim_sel].dirty) begin
                        state_d = dcache_pkg::WRITEBACK;
                    end else begin
                        state_d = dcache_pkg::FETCH;
                    end
                end
            end
            dcache_pkg::WRITEBACK: begin
                if (!wb_full_i) begin
                    state_d = dcache_pkg::FETCH;
                end
            end
            dcache_pkg::FETCH: state_d = dcache_pkg::WAIT_FILL;
            dcache_pkg::WAIT_FILL: begin
                if (fill_valid_i) begin
                    state_d = dcache_pkg::IDLE;
                end
            end
            default: state_d = dcache_pkg::RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= dcache_pkg::RESET;
            rst_cnt_q  <= '0;
            lk_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == dcache_pkg::RESET) begin
                rst_cnt_q <= rst_cnt_q + 1'b1;
            end
            if (ready_o) begin
                lk_valid_q <= req_valid_i;
            end else if (fill_done) begin
                lk_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready_o && req_valid_i) begin
            lk_write_q <= req_write_i;
            lk_addr_q  <= req_addr_i;
            lk_be_q    <= req_be_i;
            lk_wdata_q <= req_wdata_i;
        end
        if (lk_miss) begin
            victim_q <= victim_sel;
        end
    end

    // read answer from the hit way or straight from the fill
    assign rd_valid_o = (lk_hit || fill_done) && !lk_write_q;
    assign rd_data_o  = fill_done ? fill_line_i[lk_sel] : data_lines_i[hit_way][lk_sel];

    always_comb begin
        tag_wr_en_o    = '0;
        tag_wr_index_o = lk_index;
        tag_wr_entry_o = '{valid: 1'b1, dirty: lk_write_q, tag: lk_tag};
        if (state_q == dcache_pkg::RESET) begin
            tag_wr_en_o    = '1;
            tag_wr_index_o = rst_cnt_q;
            tag_wr_entry_o = '0;
        end else if (lk_hit && lk_write_q) begin
            tag_wr_en_o = tag_hit_i;
        end else if (fill_done) begin
            tag_wr_en_o[victim_q] = 1'b1;
        end
    end

    assign data_wr_way_o      = fill_done ? victim_q : hit_way;
    assign data_wr_index_o    = lk_index;
    assign data_wr_line_en_o  = fill_done;
    assign data_wr_line_o     = fill_merged;
    assign data_wr_word_en_o  = lk_hit && lk_write_q;
    assign data_wr_word_sel_o = lk_sel;
    assign data_wr_be_o       = lk_be_q;
    assign data_wr_word_o     = lk_wdata_q;

    assign plru_access_o      = lk_hit || fill_done;
    assign plru_index_o       = lk_index;
    assign plru_way_o         = fill_done ? victim_q : hit_way;
    assign plru_query_index_o = lk_index;

    // victim set is still on the read port during writeback
    assign wb_valid_o   = state_q == dcache_pkg::WRITEBACK && !wb_full_i;
    assign wb_label_o   = {tag_entries_i[victim_q].tag, lk_index};
    assign wb_line_o    = data_lines_i[victim_q];
    assign fill_req_o   = state_q == dcache_pkg::FETCH;
    assign fill_label_o = {lk_tag, lk_index};

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps
// write-back data cache
module dcache_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid_i,
    input  logic               req_write_i,
    input  dcache_pkg::addr_t  req_addr_i,
    input  dcache_pkg::be_t    req_be_i,
    input  dcache_pkg::word_t  req_wdata_i,
    output logic               ready_o,
    output logic               rd_valid_o,
    output dcache_pkg::word_t  rd_data_o,
    output logic               fill_req_o,
    output dcache_pkg::label_t fill_label_o,
    input  logic               fill_valid_i,
    input  dcache_pkg::line_t  fill_line_i,
    input  logic               wb_full_i,
    output logic               wb_valid_o,
    output dcache_pkg::label_t wb_label_o,
    output dcache_pkg::line_t  wb_line_o
);

    // tag store
    dcache_pkg::index_t                               tag_rd_index;
    dcache_pkg::tag_t                                 tag_rd_tag;
    dcache_pkg::way_mask_t                            tag_wr_en;
    dcache_pkg::index_t                               tag_wr_index;
    dcache_pkg::tag_entry_t                           tag_wr_entry;
    dcache_pkg::tag_entry_t [dcache_pkg::SET_ASSOC-1:0] tag_entries;
    dcache_pkg::way_mask_t                            tag_hit;

    // data store
    dcache_pkg::index_t                               data_rd_index;
    dcache_pkg::way_t                                 data_wr_way;
    dcache_pkg::index_t                               data_wr_index;
    logic                                             data_wr_line_en;
    dcache_pkg::line_t                                data_wr_line;
    logic                                             data_wr_word_en;
    dcache_pkg::word_sel_t                            data_wr_word_sel;
    dcache_pkg::be_t                                  data_wr_be;
    dcache_pkg::word_t                                data_wr_word;
    dcache_pkg::line_t [dcache_pkg::SET_ASSOC-1:0]    data_lines;

    // replacement
    logic                                             plru_access;
    dcache_pkg::index_t                               plru_index;
    dcache_pkg::way_t                                 plru_way;
    dcache_pkg::index_t                               plru_query_index;
    dcache_pkg::way_t                                 victim;

    dcache_ctrl u_ctrl (
        .tag_entries_i      (tag_entries),
        .tag_hit_i          (tag_hit),
        .tag_rd_index_o     (tag_rd_index),
        .tag_rd_tag_o       (tag_rd_tag),
        .tag_wr_en_o        (tag_wr_en),
        .tag_wr_index_o     (tag_wr_index),
        .tag_wr_entry_o     (tag_wr_entry),
        .data_lines_i       (data_lines),
        .data_rd_index_o    (data_rd_index),
        .data_wr_way_o      (data_wr_way),
        .data_wr_index_o    (data_wr_index),
        .data_wr_line_en_o  (data_wr_line_en),
        .data_wr_line_o     (data_wr_line),
        .data_wr_word_en_o  (data_wr_word_en),
        .data_wr_word_sel_o (data_wr_word_sel),
        .data_wr_be_o       (data_wr_be),
        .data_wr_word_o     (data_wr_word),
        .victim_i           (victim),
        .plru_access_o      (plru_access),
        .plru_index_o       (plru_index),
        .plru_way_o         (plru_way),
        .plru_query_index_o (plru_query_index),
        .*
    );

    dcache_tag_ram u_tag_ram (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (tag_rd_index),
        .rd_tag_i   (tag_rd_tag),
        .wr_en_i    (tag_wr_en),
        .wr_index_i (tag_wr_index),
        .wr_entry_i (tag_wr_entry),
        .entries_o  (tag_entries),
        .hit_o      (tag_hit)
    );

    dcache_data_ram u_data_ram (
        .clk           (clk),
        .rd_index_i    (data_rd_index),
        .wr_way_i      (data_wr_way),
        .wr_index_i    (data_wr_index),
        .wr_line_en_i  (data_wr_line_en),
        .wr_line_i     (data_wr_line),
        .wr_word_en_i  (data_wr_word_en),
        .wr_word_sel_i (data_wr_word_sel),
        .wr_be_i       (data_wr_be),
        .wr_word_i     (data_wr_word),
        .lines_o       (data_lines)
    );

    dcache_plru u_plru (
        .clk            (clk),
        .rst            (rst),
        .access_i       (plru_access),
        .access_index_i (plru_index),
        .access_way_i   (plru_way),
        .query_index_i  (plru_query_index),
        .victim_o       (victim)
    );

endmodule

//--- tests/dcache_mem_model.sv
`timescale 1ns/1ps
// cache backing memory model
module dcache_mem_model (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::word_t  ref_words_i [256],
    input  logic               fill_req_i,
    input  dcache_pkg::label_t fill_label_i,
    output logic               fill_valid_o,
    output dcache_pkg::line_t  fill_line_o,
    output logic               wb_full_o,
    input  logic               wb_valid_i,
    input  dcache_pkg::label_t wb_label_i,
    input  dcache_pkg::line_t  wb_line_i,
    output int                 err_count_o
);

    dcache_pkg::word_t  mem_words [256];
    dcache_pkg::label_t fill_label_q;
    logic               pending;
    int                 delay;

    // test lines sit at tags 0 to 7 and sets 0 to 3
    function automatic int line_base(input dcache_pkg::label_t label);
        return int'({label[6:4], label[1:0], 3'b000});
    endfunction

    // sample on the rising edge, drive on the falling edge
    initial begin
        fill_valid_o = 1'b0;
        fill_line_o  = '0;
        wb_full_o    = 1'b0;
        err_count_o  = 0;
        pending      = 1'b0;
        delay        = 0;
        forever begin
            @(posedge clk);
            if (rst) begin
                pending   = 1'b0;
                mem_words = ref_words_i;
            end else begin
                assert (!(wb_valid_i && wb_full_o)) else begin
                    err_count_o++;
                    $display("writeback strobe while the writeback level is full");
                end
                if (wb_valid_i) begin
                    for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
                        assert (wb_line_i[w] == ref_words_i[line_base(wb_label_i) + w]) else begin
                            err_count_o++;
                            $display("[FAIL] wb_line_o word %0d, label %h: got %h, expected %h",
                                     w, wb_label_i, wb_line_i[w],
                                     ref_words_i[line_base(wb_label_i) + w]);
                        end
                        mem_words[line_base(wb_label_i) + w] = wb_line_i[w];
                    end
                end
                assert (!(fill_req_i && pending)) else begin
                    err_count_o++;
                    $display("second refill request before the first one was answered");
                end
                if (fill_req_i) begin
                    pending      = 1'b1;
                    fill_label_q = fill_label_i;
                    delay        = $urandom_range(7, 0);
                end
            end
            @(negedge clk);
            fill_valid_o = 1'b0;
            wb_full_o    = !rst && $urandom_range(3, 0) == 0;
            if (pending && delay == 0) begin
                fill_valid_o = 1'b1;
                pending      = 1'b0;
                for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
                    fill_line_o[w] = mem_words[line_base(fill_label_q) + w];
                end
            end else if (pending) begin
                delay--;
            end
        end
    end

endmodule

//--- tests/dcache_tb.sv
`timescale 1ns/1ps
// data cache testbench
module dcache_tb;

    localparam int          NUM_REQ    = 2000;
    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] INIT_KEY   = 32'hc3a5_5a3c;

    logic               clk = 1'b0;
    logic               rst;
    logic               req_valid_i;
    logic               req_write_i;
    dcache_pkg::addr_t  req_addr_i;
    dcache_pkg::be_t    req_be_i;
    dcache_pkg::word_t  req_wdata_i;
    logic               ready_o;
    logic               rd_valid_o;
    dcache_pkg::word_t  rd_data_o;
    logic               fill_req_o;
    dcache_pkg::label_t fill_label_o;
    logic               fill_valid_i;
    dcache_pkg::line_t  fill_line_i;
    logic               wb_full_i;
    logic               wb_valid_o;
    dcache_pkg::label_t wb_label_o;
    dcache_pkg::line_t  wb_line_o;

    // reference words indexed by tag, set and word
    dcache_pkg::word_t  ref_words [256];
    dcache_pkg::word_t  exp_data_q [$];
    int                 exp_cycle_q [$];
    int                 errors;
    int                 mem_errors;
    int                 cycle;
    logic               timed_out;

    always #5 clk = ~clk;

    dcache_top UUT (.*);

    dcache_mem_model u_mem (
        .clk          (clk),
        .rst          (rst),
        .ref_words_i  (ref_words),
        .fill_req_i   (fill_req_o),
        .fill_label_i (fill_label_o),
        .fill_valid_o (fill_valid_i),
        .fill_line_o  (fill_line_i),
        .wb_full_o    (wb_full_i),
        .wb_valid_i   (wb_valid_o),
        .wb_label_i   (wb_label_o),
        .wb_line_i    (wb_line_o),
        .err_count_o  (mem_errors)
    );

    // tag in bits 11:9, set in 6:5, word in 4:2
    function automatic dcache_pkg::addr_t slot_addr(input int slot);
        logic [7:0] s;
        s = 8'(slot);
        return {20'd0, s[7:5], 2'b00, s[4:3], s[2:0], 2'b00};
    endfunction

    function automatic int addr_slot(input dcache_pkg::addr_t addr);
        return int'({addr[11:9], addr[6:5], addr[4:2]});
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_word,
                                                      input dcache_pkg::word_t new_word,
                                                      input dcache_pkg::be_t   be);
        dcache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // read answers arrive in request order
    task automatic check_responses();
        dcache_pkg::word_t expected;
        int                due;
        assert (!(rd_valid_o && exp_data_q.size() == 0)) else begin
            errors++;
            $display("read response at cycle %0d with no read outstanding", cycle);
        end
        if (rd_valid_o && exp_data_q.size() > 0) begin
            expected = exp_data_q.pop_front();
            due      = exp_cycle_q.pop_front();
            assert (rd_data_o == expected) else begin
                errors++;
                $display("[FAIL] rd_data_o: got %h, expected %h", rd_data_o, expected);
            end
            assert (due < 0 || cycle == due + 1) else begin
                errors++;
                $display("repeated read answered at cycle %0d, accepted at %0d", cycle, due);
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        cycle++;
        if (!rst) begin
            check_responses();
        end
    endtask

    task automatic reset_and_clear();
        int   waited;
        logic up;
        rst = 1'b1;
        repeat (4) tick();
        @(negedge clk);
        rst    = 1'b0;
        waited = 0;
        up     = 1'b0;
        while (!up && waited < WAIT_LIMIT) begin
            tick();
            assert (!fill_req_o && !wb_valid_o && !rd_valid_o) else begin
                errors++;
                $display("memory or read strobe active while the tags clear");
            end
            if (ready_o) begin
                up = 1'b1;
            end else begin
                waited++;
            end
        end
        assert (up) else begin
            errors++;
            timed_out = 1'b1;
            $display("timeout waiting for ready_o after reset");
        end
        assert (!up || waited == dcache_pkg::SET_NUM) else begin
            errors++;
            $display("ready_o rose after %0d cycles of tag clearing", waited);
        end
    endtask

    task automatic send_request(input logic              write,
                                input dcache_pkg::addr_t addr,
                                input dcache_pkg::be_t   be,
                                input dcache_pkg::word_t wdata,
                                input logic              quick);
        int   waited;
        logic accepted;
        @(negedge clk);
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_be_i    = be;
        req_wdata_i = wdata;
        waited      = 0;
        accepted    = 1'b0;
        while (!accepted && waited < WAIT_LIMIT) begin
            tick();
            if (ready_o) begin
                accepted = 1'b1;
            end else begin
                waited++;
            end
        end
        assert (accepted) else begin
            errors++;
            timed_out = 1'b1;
            $display("timeout waiting for ready_o with a request pending");
        end
        if (accepted && write) begin
            ref_words[addr_slot(addr)] = merge_bytes(ref_words[addr_slot(addr)], wdata, be);
        end else if (accepted) begin
            exp_data_q.push_back(ref_words[addr_slot(addr)]);
            exp_cycle_q.push_back(quick ? cycle : -1);
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        req_valid_i = 1'b0;
        tick();
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while ((exp_data_q.size() > 0 || !ready_o) && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        assert (exp_data_q.size() == 0 && ready_o) else begin
            errors++;
            $display("timeout waiting for outstanding reads to complete");
        end
    endtask

    initial begin
        dcache_pkg::addr_t addr;
        dcache_pkg::addr_t prev_addr;
        logic              write;
        logic              quick;
        void'($urandom(32'h11761da8));
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_be_i    = '0;
        req_wdata_i = '0;
        errors      = 0;
        cycle       = 0;
        timed_out   = 1'b0;
        prev_addr   = '0;
        for (int k = 0; k < 256; k++) begin
            ref_words[k] = slot_addr(k) ^ INIT_KEY;
        end
        reset_and_clear();
        for (int n = 0; n < NUM_REQ && !timed_out; n++) begin
            // a quarter of the requests reread the word just accessed
            quick = n > 0 && $urandom_range(3, 0) == 0;
            write = !quick && $urandom_range(1, 0) == 1;
            addr  = quick ? prev_addr : slot_addr($urandom_range(255, 0));
            if ($urandom_range(7, 0) == 0) begin
                idle_cycle();
            end
            send_request(write, addr, 4'($urandom_range(15, 1)), $urandom, quick);
            prev_addr = addr;
        end
        @(negedge clk);
        req_valid_i = 1'b0;
        drain_responses();
        $display("errors: %0d in testbench, %0d in memory model", errors, mem_errors);
        if (errors == 0 && mem_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/dcache_pkg.sv
logic/dcache_tag_ram.sv
logic/dcache_data_ram.sv
logic/dcache_plru.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing --assert --top-module dcache_tb -f verilog.f -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
